//--- sim.f
source/xge_pkg.sv
source/pkt_fifo.sv
source/xge_rx_pad_insert.sv
source/xge_tx_pad_strip.sv
source/tx_pkt_gate.sv
source/xge_mac_client.sv
verif/xge_mac_client_tb.sv

//--- Bender.yml
package:
  name: xge_mac_client

sources:
  - source/xge_pkg.sv
  - source/pkt_fifo.sv
  - source/xge_rx_pad_insert.sv
  - source/xge_tx_pad_strip.sv
  - source/tx_pkt_gate.sv
  - source/xge_mac_client.sv
  - target: test
    files:
      - verif/xge_mac_client_tb.sv

//--- verif/xge_mac_client_tb.sv
/*
 * Testbench for the XGE MAC client wrapper with port label 8'h5a.
 * Models the MAC packet interface and both client streams, and checks
 * each path against word queues built from the framing rules.
 * Stimulus comes from a Galois LFSR with seed 45.
 */
`timescale 1ns/1ps
`default_nettype none

module xge_mac_client_tb;
   import xge_pkg::*;

   localparam logic [7:0] label      = 8'h5a;
   localparam int         num_tests  = 4;
   localparam int         num_frames = 6;

   logic      clk = 1'b0;
   logic      rst;
   logic      pkt_rx_avail, pkt_rx_val, pkt_rx_sop, pkt_rx_eop, pkt_rx_err, pkt_rx_ren;
   xge_data_t pkt_rx_data;
   xge_occ_t  pkt_rx_mod;
   xge_data_t pkt_tx_data;
   xge_occ_t  pkt_tx_mod;
   logic      pkt_tx_val, pkt_tx_sop, pkt_tx_eop, pkt_tx_full;
   xge_data_t rx_tdata, tx_tdata;
   xge_user_t rx_tuser, tx_tuser;
   logic      rx_tlast, rx_tvalid, rx_tready;
   logic      tx_tlast, tx_tvalid, tx_tready;

   logic [31:0] lfsr_state;
   int          frame_len [num_tests][num_frames];
   int          total_words;
   int          errors, checks, tests_run, tests_failed, err_before;
   int          tx_frames_in, tx_frames_out;
   logic        tx_in_frame;
   logic        rx_stall_mode, tx_full_mode;
   string       test_name;

   // MAC RX words still to be read, ctl is sop, eop, err, mod
   xge_data_t   mac_rx_data_q[$];
   logic [5:0]  mac_rx_ctl_q[$];
   // Client TX words still to be sent, ctl is last, user
   xge_data_t   tx_in_data_q[$];
   logic [4:0]  tx_in_ctl_q[$];
   // Expected client RX words, ctl is last, user, valid bytes
   xge_data_t   exp_rx_data_q[$];
   logic [8:0]  exp_rx_ctl_q[$];
   // Expected MAC TX words, ctl is sop, eop, mod, valid bytes
   xge_data_t   exp_tx_data_q[$];
   logic [8:0]  exp_tx_ctl_q[$];
   logic [7:0]  frame_bytes[$];

   xge_data_t   rx_exp_data, tx_exp_data;
   logic [8:0]  rx_exp_ctl, tx_exp_ctl;

   xge_mac_client #(.port_label(label)) i_dut (
      .clk(clk), .rst(rst),
      .pkt_rx_avail(pkt_rx_avail), .pkt_rx_data(pkt_rx_data), .pkt_rx_val(pkt_rx_val),
      .pkt_rx_sop(pkt_rx_sop), .pkt_rx_eop(pkt_rx_eop), .pkt_rx_mod(pkt_rx_mod),
      .pkt_rx_err(pkt_rx_err), .pkt_rx_ren(pkt_rx_ren),
      .pkt_tx_data(pkt_tx_data), .pkt_tx_mod(pkt_tx_mod), .pkt_tx_val(pkt_tx_val),
      .pkt_tx_sop(pkt_tx_sop), .pkt_tx_eop(pkt_tx_eop), .pkt_tx_full(pkt_tx_full),
      .rx_tdata(rx_tdata), .rx_tuser(rx_tuser), .rx_tlast(rx_tlast),
      .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
      .tx_tdata(tx_tdata), .tx_tuser(tx_tuser), .tx_tlast(tx_tlast),
      .tx_tvalid(tx_tvalid), .tx_tready(tx_tready)
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic lfsr_step();
      logic lsb;
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return lsb;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         r = {r[62:0], lfsr_step()};
      end
      return r;
   endfunction

   // Keeps the leading nb bytes of a word
   function automatic xge_data_t byte_mask(input int nb);
      return {64{1'b1}} << (64 - 8 * nb);
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("Error in test %s: %s", test_name, msg);
   endtask

   // Splits frame_bytes into the expected words of one path
   task automatic expect_words(input logic to_mac, input logic err);
      int        nbytes, nwords, nb, i, b;
      xge_data_t w;
      logic      last;
      nbytes = frame_bytes.size();
      nwords = (nbytes + 7) / 8;
      for (i = 0; i < nwords; i++) begin
         w  = '0;
         nb = 0;
         for (b = 0; b < 8; b++) begin
            if (8 * i + b < nbytes) begin
               w[63 - 8 * b -: 8] = frame_bytes[8 * i + b];
               nb++;
            end
         end
         last = (i == nwords - 1);
         if (to_mac) begin
            exp_tx_data_q.push_back(w);
            exp_tx_ctl_q.push_back({i == 0, last, 3'(nbytes % 8), 4'(nb)});
         end else begin
            exp_rx_data_q.push_back(w);
            exp_rx_ctl_q.push_back({last, last && err, 3'(nbytes % 8), 4'(nb)});
         end
      end
      frame_bytes.delete();
   endtask

   task automatic send_rx_frame(input int nwords);
      xge_occ_t  mod;
      logic      err, last;
      xge_data_t w;
      int        nb, i, b;
      mod = rand_bits(3);
      err = rand_bits(1);
      // Client sees the label, five zero bytes, then the MAC bytes
      frame_bytes.push_back(label);
      for (i = 1; i < pad_bytes; i++) begin
         frame_bytes.push_back(8'h00);
      end
      for (i = 0; i < nwords; i++) begin
         w    = rand_bits(64);
         last = (i == nwords - 1);
         nb   = (last && mod != 0) ? mod : 8;
         for (b = 0; b < nb; b++) begin
            frame_bytes.push_back(w[63 - 8 * b -: 8]);
         end
         mac_rx_data_q.push_back(w);
         mac_rx_ctl_q.push_back({i == 0, last, err && last, last ? mod : 3'd0});
      end
      expect_words(1'b0, err);
   endtask

   task automatic send_tx_frame(input int nwords);
      xge_occ_t  occ;
      logic      last;
      xge_data_t w;
      int        nb, i, b;
      occ = rand_bits(3);
      for (i = 0; i < nwords; i++) begin
         w    = rand_bits(64);
         last = (i == nwords - 1);
         nb   = (last && occ != 0) ? occ : 8;
         // MAC sees everything after the pad
         for (b = 0; b < nb; b++) begin
            if (8 * i + b >= pad_bytes) begin
               frame_bytes.push_back(w[63 - 8 * b -: 8]);
            end
         end
         tx_in_data_q.push_back(w);
         tx_in_ctl_q.push_back({last, 1'b0, last ? occ : 3'd0});
      end
      expect_words(1'b1, 1'b0);
   endtask

   // One clock of MAC RX model, client TX driver and stall patterns
   task automatic step_cycle();
      logic       ren_s, tx_taken;
      logic [5:0] ctl;
      @(posedge clk);
      ren_s    = pkt_rx_ren;
      tx_taken = tx_tvalid && tx_tready;
      #1;
      pkt_rx_val = 1'b0;
      {pkt_rx_sop, pkt_rx_eop, pkt_rx_err, pkt_rx_mod} = '0;
      if (ren_s) begin
         if (mac_rx_data_q.size() == 0) begin
            report_error("pkt_rx_ren was high with no MAC word left to read");
         end else begin
            ctl         = mac_rx_ctl_q.pop_front();
            pkt_rx_data = mac_rx_data_q.pop_front();
            pkt_rx_val  = 1'b1;
            {pkt_rx_sop, pkt_rx_eop, pkt_rx_err, pkt_rx_mod} = ctl;
         end
      end
      pkt_rx_avail = (mac_rx_data_q.size() != 0);
      if (tx_taken) begin
         void'(tx_in_data_q.pop_front());
         void'(tx_in_ctl_q.pop_front());
      end
      tx_tvalid = (tx_in_data_q.size() != 0);
      if (tx_tvalid) begin
         tx_tdata             = tx_in_data_q[0];
         {tx_tlast, tx_tuser} = tx_in_ctl_q[0];
      end
      rx_tready   = rx_stall_mode ? rand_bits(1) : 1'b1;
      pkt_tx_full = tx_full_mode ? (rand_bits(2) == 0) : 1'b0;
   endtask

   task automatic run_until_drained();
      while (mac_rx_data_q.size() != 0 || tx_in_data_q.size() != 0 ||
             exp_rx_data_q.size() != 0 || exp_tx_data_q.size() != 0) begin
         step_cycle();
      end
      // Stray words would show up here
      repeat (10) step_cycle();
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors != err_before) begin
         tests_failed++;
      end
      $display("test %s finished with %0d errors", test_name, errors - err_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitors
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!rst && rx_tvalid && rx_tready) begin
         if (exp_rx_data_q.size() == 0) begin
            report_error("client RX word arrived with no frame expected");
         end else begin
            rx_exp_data = exp_rx_data_q.pop_front();
            rx_exp_ctl  = exp_rx_ctl_q.pop_front();
            check_value($sformatf("%s rx_tdata", test_name), rx_exp_data,
                        rx_tdata & byte_mask(rx_exp_ctl[3:0]));
            check_value($sformatf("%s rx_tlast", test_name), rx_exp_ctl[8], rx_tlast);
            if (rx_exp_ctl[8]) begin
               check_value($sformatf("%s rx_tuser", test_name), rx_exp_ctl[7:4], rx_tuser);
            end else begin
               check_value($sformatf("%s rx_tuser[3]", test_name), 1'b0, rx_tuser[3]);
            end
         end
      end
   end

   always @(posedge clk) begin
      if (!rst) begin
         if (pkt_tx_val && pkt_tx_full) begin
            report_error("pkt_tx_val was high while pkt_tx_full was high");
         end
         if (tx_in_frame && !pkt_tx_full && !pkt_tx_val) begin
            report_error("MAC TX frame paused while pkt_tx_full was low");
         end
         if (pkt_tx_val) begin
            if (exp_tx_data_q.size() == 0) begin
               report_error("MAC TX word arrived with no frame expected");
            end else begin
               tx_exp_data = exp_tx_data_q.pop_front();
               tx_exp_ctl  = exp_tx_ctl_q.pop_front();
               check_value($sformatf("%s pkt_tx_data", test_name), tx_exp_data,
                           pkt_tx_data & byte_mask(tx_exp_ctl[3:0]));
               check_value($sformatf("%s pkt_tx_sop", test_name), tx_exp_ctl[8], pkt_tx_sop);
               check_value($sformatf("%s pkt_tx_eop", test_name), tx_exp_ctl[7], pkt_tx_eop);
               if (tx_exp_ctl[7]) begin
                  check_value($sformatf("%s pkt_tx_mod", test_name), tx_exp_ctl[6:4],
                              pkt_tx_mod);
               end
            end
            if (pkt_tx_sop) begin
               if (tx_frames_out >= tx_frames_in) begin
                  report_error("pkt_tx_sop came before the frame's tlast was accepted");
               end
               tx_frames_out++;
            end
            tx_in_frame = !pkt_tx_eop;
         end
         // Counted after the sop check, so a same-cycle tlast does not release a frame
         if (tx_tvalid && tx_tready && tx_tlast) begin
            tx_frames_in++;
         end
      end
   end

   // Watchdog, armed once the test lengths are known
   initial begin
      wait (total_words != 0);
      repeat (total_words * 20) @(posedge clk);
      $display("Run timed out after %0d cycles with frames still in flight",
               total_words * 20);
      $display("ERRORS FOUND");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int t, f, sum;
      rst          = 1'b1;
      pkt_rx_avail = 1'b0;
      pkt_rx_data  = '0;
      pkt_rx_val   = 1'b0;
      pkt_rx_sop   = 1'b0;
      pkt_rx_eop   = 1'b0;
      pkt_rx_mod   = '0;
      pkt_rx_err   = 1'b0;
      pkt_tx_full  = 1'b0;
      rx_tready    = 1'b1;
      tx_tdata     = '0;
      tx_tuser     = '0;
      tx_tlast     = 1'b0;
      tx_tvalid    = 1'b0;
      {rx_stall_mode, tx_full_mode, tx_in_frame} = '0;
      {errors, checks, tests_run, tests_failed} = '0;
      {tx_frames_in, tx_frames_out, total_words} = '0;
      lfsr_state = 32'd45;
      sum        = 0;
      for (t = 0; t < num_tests; t++) begin
         for (f = 0; f < num_frames; f++) begin
            frame_len[t][f] = 3 + rand_bits(5) % 18;
            sum += frame_len[t][f];
         end
      end
      total_words = sum;

      test_name  = "reset";
      err_before = errors;
      repeat (3) @(posedge clk);
      check_value("reset tx_tready", 1'b0, tx_tready);
      #1;
      rst = 1'b0;
      @(posedge clk);
      check_value("reset pkt_rx_ren", 1'b0, pkt_rx_ren);
      check_value("reset rx_tvalid", 1'b0, rx_tvalid);
      check_value("reset pkt_tx_val", 1'b0, pkt_tx_val);
      check_value("reset pkt_tx_sop", 1'b0, pkt_tx_sop);
      check_value("reset pkt_tx_eop", 1'b0, pkt_tx_eop);
      check_value("reset tx_tready", 1'b1, tx_tready);
      finish_test();

      for (t = 0; t < num_tests; t++) begin
         case (t)
            0:       test_name = "rx_pad";
            1:       test_name = "rx_stall";
            2:       test_name = "tx_strip";
            default: test_name = "tx_full";
         endcase
         err_before    = errors;
         rx_stall_mode = (t == 1);
         tx_full_mode  = (t == 3);
         for (f = 0; f < num_frames; f++) begin
            if (t < 2) begin
               send_rx_frame(frame_len[t][f]);
            end else begin
               send_tx_frame(frame_len[t][f]);
            end
         end
         run_until_drained();
         finish_test();
      end

      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- source/xge_mac_client.sv
/*
 * Client side of a 10G Ethernet MAC on one clock.
 * RX frames gain a 6-byte pad led by port_label, TX frames lose it.
 * TX is store-and-forward. Frames must be at least 3 words long.
 */
`timescale 1ns/1ps
`default_nettype none

module xge_mac_client #(
   parameter logic [7:0] port_label = 8'h00
) (
   input  wire                     clk,
   input  wire                     rst,
   // MAC RX packet interface
   input  wire                     pkt_rx_avail,
   input  wire xge_pkg::xge_data_t pkt_rx_data,
   input  wire                     pkt_rx_val,
   input  wire                     pkt_rx_sop,
   input  wire                     pkt_rx_eop,
   input  wire xge_pkg::xge_occ_t  pkt_rx_mod,
   input  wire                     pkt_rx_err,
   output wire                     pkt_rx_ren,
   // MAC TX packet interface
   output wire xge_pkg::xge_data_t pkt_tx_data,
   output wire xge_pkg::xge_occ_t  pkt_tx_mod,
   output wire                     pkt_tx_val,
   output wire                     pkt_tx_sop,
   output wire                     pkt_tx_eop,
   input  wire                     pkt_tx_full,
   // Client RX stream
   output wire xge_pkg::xge_data_t rx_tdata,
   output wire xge_pkg::xge_user_t rx_tuser,
   output wire                     rx_tlast,
   output wire                     rx_tvalid,
   input  wire                     rx_tready,
   // Client TX stream
   input  wire xge_pkg::xge_data_t tx_tdata,
   input  wire xge_pkg::xge_user_t tx_tuser,
   input  wire                     tx_tlast,
   input  wire                     tx_tvalid,
   output wire                     tx_tready
);
   import xge_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // RX chain
   ////////////////////////////////////////////////////////////////////////////

   wire xge_data_t rx_pad_data;
   wire xge_user_t rx_pad_user;
   wire            rx_pad_last, rx_pad_valid, rx_pad_ready;

   xge_rx_pad_insert #(.port_label(port_label)) rx_pad (
      .clk(clk), .rst(rst),
      .pkt_rx_avail(pkt_rx_avail), .pkt_rx_val(pkt_rx_val),
      .pkt_rx_sop(pkt_rx_sop), .pkt_rx_eop(pkt_rx_eop),
      .pkt_rx_err(pkt_rx_err), .pkt_rx_data(pkt_rx_data),
      .pkt_rx_mod(pkt_rx_mod), .pkt_rx_ren(pkt_rx_ren),
      .m_tdata(rx_pad_data), .m_tuser(rx_pad_user), .m_tlast(rx_pad_last),
      .m_tvalid(rx_pad_valid), .m_tready(rx_pad_ready)
   );

   pkt_fifo rx_fifo (
      .clk(clk), .rst(rst),
      .i_tdata(rx_pad_data), .i_tuser(rx_pad_user), .i_tlast(rx_pad_last),
      .i_tvalid(rx_pad_valid), .i_tready(rx_pad_ready),
      .o_tdata(rx_tdata), .o_tuser(rx_tuser), .o_tlast(rx_tlast),
      .o_tvalid(rx_tvalid), .o_tready(rx_tready)
   );

   ////////////////////////////////////////////////////////////////////////////
   // TX chain
   ////////////////////////////////////////////////////////////////////////////

   wire xge_data_t tx_buf_data, tx_str_data;
   wire xge_user_t tx_buf_user, tx_str_user;
   wire            tx_buf_last, tx_buf_valid, tx_buf_ready;
   wire            tx_str_last, tx_str_valid, tx_str_ready;
   wire            tx_q_sof, tx_q_valid, tx_q_ready;

   pkt_fifo tx_fifo_in (
      .clk(clk), .rst(rst),
      .i_tdata(tx_tdata), .i_tuser(tx_tuser), .i_tlast(tx_tlast),
      .i_tvalid(tx_tvalid), .i_tready(tx_tready),
      .o_tdata(tx_buf_data), .o_tuser(tx_buf_user), .o_tlast(tx_buf_last),
      .o_tvalid(tx_buf_valid), .o_tready(tx_buf_ready)
   );

   xge_tx_pad_strip tx_strip (
      .clk(clk), .rst(rst),
      .s_tdata(tx_buf_data), .s_tuser(tx_buf_user), .s_tlast(tx_buf_last),
      .s_tvalid(tx_buf_valid), .s_tready(tx_buf_ready),
      .m_tdata(tx_str_data), .m_tuser(tx_str_user), .m_tlast(tx_str_last),
      .m_tvalid(tx_str_valid), .m_tready(tx_str_ready)
   );

   // Holds whole frames so the MAC never underruns
   pkt_fifo tx_fifo_pkt (
      .clk(clk), .rst(rst),
      .i_tdata(tx_str_data), .i_tuser(tx_str_user), .i_tlast(tx_str_last),
      .i_tvalid(tx_str_valid), .i_tready(tx_str_ready),
      .o_tdata(pkt_tx_data), .o_tuser({tx_q_sof, pkt_tx_mod}), .o_tlast(pkt_tx_eop),
      .o_tvalid(tx_q_valid), .o_tready(tx_q_ready)
   );

   tx_pkt_gate tx_gate (
      .clk(clk), .rst(rst),
      .in_tvalid(tx_str_valid), .in_tready(tx_str_ready), .in_tlast(tx_str_last),
      .fifo_tvalid(tx_q_valid), .fifo_tsof(tx_q_sof), .fifo_tlast(pkt_tx_eop),
      .fifo_tready(tx_q_ready), .pkt_tx_full(pkt_tx_full),
      .pkt_tx_val(pkt_tx_val), .pkt_tx_sop(pkt_tx_sop)
   );

endmodule

`default_nettype wire

//--- source/tx_pkt_gate.sv
/*
 * Store-and-forward gate for the MAC transmit side.
 * A frame is released only after its last word is in the TX FIFO,
 * so it leaves without underrun. Output pauses while the MAC is full.
 */
`timescale 1ns/1ps
`default_nettype none

module tx_pkt_gate (
   input  wire  clk,
   input  wire  rst,
   input  wire  in_tvalid,
   input  wire  in_tready,
   input  wire  in_tlast,
   input  wire  fifo_tvalid,
   input  wire  fifo_tsof,
   input  wire  fifo_tlast,
   output logic fifo_tready,
   input  wire  pkt_tx_full,
   output logic pkt_tx_val,
   output logic pkt_tx_sop
);
   import xge_pkg::*;

   // Whole frames held in the FIFO, the one leaving included
   logic [fifo_addr_w:0] pkt_cnt;
   logic                 push_eof;
   logic                 pop_eof;

   assign push_eof = in_tvalid && in_tready && in_tlast;
   assign pop_eof  = pkt_tx_val && fifo_tlast;

   // Frames leave in order, so a nonzero count means the head frame is complete
   assign fifo_tready = (pkt_cnt != '0) && !pkt_tx_full;
   assign pkt_tx_val  = fifo_tvalid && fifo_tready;
   assign pkt_tx_sop  = pkt_tx_val && fifo_tsof;

   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_cnt <= '0;
      end else if (push_eof && !pop_eof) begin
         pkt_cnt <= pkt_cnt + 1'b1;
      end else if (pop_eof && !push_eof) begin
         pkt_cnt <= pkt_cnt - 1'b1;
      end
   end

   // Every frame end that leaves was counted on entry
   assert property (@(posedge clk) disable iff (rst) pop_eof |-> pkt_cnt != '0);

   // MAC never written while full
   assert property (@(posedge clk) disable iff (rst) pkt_tx_full |-> !pkt_tx_val);

   // Once started, the FIFO keeps a word ready until the frame ends
   assert property (@(posedge clk) disable iff (rst)
      pkt_tx_val && !fifo_tlast |=> fifo_tvalid);

endmodule

`default_nettype wire

//--- source/xge_tx_pad_strip.sv
/*
 * TX pad stripper with a one-word delay.
 * Drops the first 6 bytes of each frame and flags start of frame in tuser bit 3.
 * Frames must be at least 3 words long. Input tuser bit 3 is ignored.
 */
`timescale 1ns/1ps
`default_nettype none

module xge_tx_pad_strip (
   input  wire                     clk,
   input  wire                     rst,
   input  wire xge_pkg::xge_data_t s_tdata,
   input  wire xge_pkg::xge_user_t s_tuser,
   input  wire                     s_tlast,
   input  wire                     s_tvalid,
   output logic                    s_tready,
   output xge_pkg::xge_data_t      m_tdata,
   output xge_pkg::xge_user_t      m_tuser,
   output logic                    m_tlast,
   output logic                    m_tvalid,
   input  wire                     m_tready
);
   import xge_pkg::*;

   xge_data_t held_q;
   xge_occ_t  occ_q;
   logic      held_v;
   logic      held_tail;
   logic      sof_q;
   xge_occ_t  in_occ;
   logic      in_long;
   logic      s_xfer;

   // Two bytes of the held word lead each output word
   assign in_occ  = xge_occ_t'(s_tuser[2:0] + 3'(8 - pad_bytes));
   // 7 or 8 bytes in the last input word leave a tail of 1 or 2 bytes
   assign in_long = (s_tuser[2:0] == 3'd0) || (s_tuser[2:0] == 3'd7);
   assign s_xfer  = s_tvalid && s_tready;

   always_comb begin
      if (held_tail) begin
         m_tvalid = 1'b1;
         m_tdata  = {held_q[15:0], 48'h0};
         m_tlast  = 1'b1;
         m_tuser  = {1'b0, occ_q};
         s_tready = 1'b0;
      end else begin
         m_tvalid = held_v && s_tvalid;
         m_tdata  = {held_q[15:0], s_tdata[63:16]};
         m_tlast  = s_tlast && !in_long;
         m_tuser  = {sof_q, (s_tlast && !in_long) ? in_occ : 3'd0};
         // First word of a frame is only absorbed
         s_tready = held_v ? m_tready : 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         held_v    <= 1'b0;
         held_tail <= 1'b0;
         sof_q     <= 1'b0;
      end else if (held_tail) begin
         if (m_tready) begin
            held_v    <= 1'b0;
            held_tail <= 1'b0;
         end
      end else if (s_xfer) begin
         if (!held_v) begin
            held_v <= 1'b1;
            sof_q  <= 1'b1;
         end else begin
            sof_q <= 1'b0;
            if (s_tlast && in_long) begin
               held_tail <= 1'b1;
            end else if (s_tlast) begin
               held_v <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (s_xfer) begin
         held_q <= s_tdata;
         occ_q  <= in_occ;
      end
   end

endmodule

`default_nettype wire

//--- source/xge_rx_pad_insert.sv
/*
 * RX pad inserter with MAC read-enable control.
 * Puts port_label and five zero bytes in front of every frame.
 * Frames must be at least 3 words long.
 * The MAC must answer each read enable with one word a cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module xge_rx_pad_insert #(
   parameter logic [7:0] port_label = 8'h00
) (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     pkt_rx_avail,
   input  wire                     pkt_rx_val,
   input  wire                     pkt_rx_sop,
   input  wire                     pkt_rx_eop,
   input  wire                     pkt_rx_err,
   input  wire xge_pkg::xge_data_t pkt_rx_data,
   input  wire xge_pkg::xge_occ_t  pkt_rx_mod,
   output logic                    pkt_rx_ren,
   output xge_pkg::xge_data_t      m_tdata,
   output xge_pkg::xge_user_t      m_tuser,
   output logic                    m_tlast,
   output logic                    m_tvalid,
   input  wire                     m_tready
);
   import xge_pkg::*;

   typedef enum logic [1:0] {st_idle, st_reading, st_extra} rx_state_t;

   rx_state_t   state;

   // Holds the one MAC word in flight when the output stalls
   logic        skid_valid;
   xge_data_t   skid_data;
   xge_occ_t    skid_mod;
   logic        skid_sop, skid_eop, skid_err;

   // Word being merged this cycle
   logic        src_val, src_sop, src_eop, src_err;
   xge_data_t   src_data;
   xge_occ_t    src_mod;
   xge_occ_t    src_occ;

   logic [47:0] tail_q;
   xge_occ_t    occ_q;
   logic        err_q;

   logic        load_ok, do_load, room, need_extra;
   xge_data_t   nxt_data;
   xge_user_t   nxt_user;
   logic        nxt_last;

   assign load_ok = !m_tvalid || m_tready;
   assign room    = load_ok && !skid_valid;

   assign src_val  = skid_valid || pkt_rx_val;
   assign src_data = skid_valid ? skid_data : pkt_rx_data;
   assign src_mod  = skid_valid ? skid_mod : pkt_rx_mod;
   assign src_sop  = skid_valid ? skid_sop : pkt_rx_sop;
   assign src_eop  = skid_valid ? skid_eop : pkt_rx_eop;
   assign src_err  = skid_valid ? skid_err : pkt_rx_err;

   assign src_occ    = xge_occ_t'(src_mod + 3'(pad_bytes));
   // More than two bytes in the last MAC word spill into one more word
   assign need_extra = (src_mod == 3'd0) || (src_mod > 3'd2);
   assign do_load    = (state == st_extra) || src_val;

   always_comb begin
      case (state)
         st_idle:    pkt_rx_ren = pkt_rx_avail && room;
         st_reading: pkt_rx_ren = room && !(pkt_rx_val && pkt_rx_eop);
         default:    pkt_rx_ren = 1'b0;
      endcase
   end

   always_comb begin
      nxt_last = 1'b0;
      nxt_user = '0;
      if (state == st_extra) begin
         nxt_data = {tail_q, 16'h0000};
         nxt_last = 1'b1;
         nxt_user = {err_q, occ_q};
      end else begin
         if (src_sop) begin
            nxt_data = {port_label, {(pad_bytes - 1) * 8{1'b0}}, src_data[63:48]};
         end else begin
            nxt_data = {tail_q, src_data[63:48]};
         end
         if (src_eop && !need_extra) begin
            nxt_last = 1'b1;
            nxt_user = {src_err, src_occ};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_idle;
         skid_valid <= 1'b0;
         m_tvalid   <= 1'b0;
      end else begin
         if (load_ok) begin
            m_tvalid   <= do_load;
            skid_valid <= 1'b0;
         end else if (pkt_rx_val) begin
            skid_valid <= 1'b1;
         end
         case (state)
            st_idle: begin
               if (pkt_rx_ren) begin
                  state <= st_reading;
               end
            end
            st_reading: begin
               if (src_val && src_eop && load_ok) begin
                  state <= need_extra ? st_extra : st_idle;
               end
            end
            default: begin
               if (load_ok) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pkt_rx_val && !load_ok) begin
         skid_data <= pkt_rx_data;
         skid_mod  <= pkt_rx_mod;
         skid_sop  <= pkt_rx_sop;
         skid_eop  <= pkt_rx_eop;
         skid_err  <= pkt_rx_err;
      end
      if (load_ok && do_load) begin
         m_tdata <= nxt_data;
         m_tuser <= nxt_user;
         m_tlast <= nxt_last;
      end
      if (load_ok && src_val) begin
         tail_q <= src_data[47:0];
         occ_q  <= src_occ;
         err_q  <= src_err;
      end
   end

   // The MAC only returns words that were asked for
   assert property (@(posedge clk) disable iff (rst) pkt_rx_val |-> $past(pkt_rx_ren));

endmodule

`default_nettype wire

//--- source/pkt_fifo.sv
/*
 * Single-clock stream FIFO with a registered output.
 * A word written into an empty FIFO is valid at the output 2 cycles later.
 * The input is not ready during reset.
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo (
   input  wire                     clk,
   input  wire                     rst,
   input  wire xge_pkg::xge_data_t i_tdata,
   input  wire xge_pkg::xge_user_t i_tuser,
   input  wire                     i_tlast,
   input  wire                     i_tvalid,
   output logic                    i_tready,
   output xge_pkg::xge_data_t      o_tdata,
   output xge_pkg::xge_user_t      o_tuser,
   output logic                    o_tlast,
   output logic                    o_tvalid,
   input  wire                     o_tready
);
   import xge_pkg::*;

   logic [fifo_w-1:0]    mem [2**fifo_addr_w];
   logic [fifo_w-1:0]    out_q;
   logic [fifo_addr_w:0] wr_ptr;
   logic [fifo_addr_w:0] rd_ptr;
   logic [fifo_addr_w:0] used;
   logic                 full;
   logic                 wr_en;
   logic                 rd_en;

   // Extra pointer bit lets used reach the full depth
   assign used     = wr_ptr - rd_ptr;
   assign full     = used[fifo_addr_w];
   assign i_tready = !full && !rst;
   assign wr_en    = i_tvalid && i_tready;

   // Refill the output register whenever it empties or is taken
   assign rd_en = (used != '0) && (!o_tvalid || o_tready);

   assign {o_tlast, o_tuser, o_tdata} = out_q;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[fifo_addr_w-1:0]] <= {i_tlast, i_tuser, i_tdata};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         o_tvalid <= 1'b0;
         out_q    <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr   <= rd_ptr + 1'b1;
            out_q    <= mem[rd_ptr[fifo_addr_w-1:0]];
            o_tvalid <= 1'b1;
         end else if (o_tready) begin
            o_tvalid <= 1'b0;
         end
      end
   end

   // Occupancy never passes the depth, so no write lands on a full memory
   assert property (@(posedge clk) disable iff (rst)
      used <= (fifo_addr_w + 1)'(2**fifo_addr_w));

endmodule

`default_nettype wire

//--- source/xge_pkg.sv
/*
 * Shared types and sizes for the XGE MAC client wrapper.
 * Bytes are big-endian: byte 0 of a word sits in bits 63:56.
 * An occupancy of 0 means all 8 bytes of the word are valid.
 */
`default_nettype none

package xge_pkg;

   // One word of frame data, 8 bytes
   typedef logic [63:0] xge_data_t;

   // Valid bytes in the last word of a frame
   typedef logic [2:0]  xge_occ_t;

   // Occupancy in bits 2:0, RX error or TX start of frame in bit 3
   typedef logic [3:0]  xge_user_t;

   // Bytes in front of every client frame
   localparam int pad_bytes = 6;

   // 1024 words hold a maximum-size frame
   localparam int fifo_addr_w = 10;

   // Entry holds last, user and data
   localparam int fifo_w = $bits(xge_data_t) + $bits(xge_user_t) + 1;

endpackage

`default_nettype wire
